// ==== logic/fft_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft_addr_gen #(
    parameter int n_points = 16,
    parameter int log2_n   = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output fft_pkg::rd_req_t    rd_req,
    output logic                rd_valid,
    output logic [log2_n-2:0]   tw_idx,
    output logic                tw_en,
    output logic                pair_upper,
    output logic                stage_last_pair,
    output logic                done,
    output logic                busy
);

    localparam int stage_w = $clog2(log2_n);

    // one-hot state bits
    localparam int i_idle  = 0;
    localparam int i_rd0   = 1;
    localparam int i_rd1   = 2;
    localparam int i_drain = 3;
    localparam int i_done  = 4;

    localparam logic [4:0] st_idle  = 5'b00001;
    localparam logic [4:0] st_rd0   = 5'b00010;
    localparam logic [4:0] st_rd1   = 5'b00100;
    localparam logic [4:0] st_drain = 5'b01000;
    localparam logic [4:0] st_done  = 5'b10000;

    logic [4:0]         state;
    logic [4:0]         state_nxt;
    logic [stage_w-1:0] stage;
    logic [log2_n-2:0]  group;      // butterfly group within the stage
    logic [log2_n-2:0]  k;          // element within the group
    logic [1:0]         drain_cnt;

    logic [log2_n-1:0]  span;
    logic [log2_n-2:0]  span_m1;
    logic [log2_n-2:0]  group_last;
    logic [log2_n-1:0]  grp_base;
    logic [log2_n-1:0]  addr_lo;
    logic [log2_n-1:0]  addr_hi;
    logic               last_k;
    logic               last_group;
    logic               last_stage;
    logic               drain_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        span       = log2_n'(n_points >> (stage + 1));
        span_m1    = (log2_n-1)'((n_points >> (stage + 1)) - 1);
        group_last = (log2_n-1)'((1 << stage) - 1);
        grp_base   = {1'b0, group} << (log2_n - stage);  // group * 2 * span
        addr_lo    = grp_base + {1'b0, k};
        addr_hi    = addr_lo + span;
        last_k     = (k == span_m1);
        last_group = (group == group_last);
        last_stage = (stage == stage_w'(log2_n - 1));
        drain_end  = (drain_cnt == 2'd2);
    end

    always_comb begin
        rd_req.addr = fft_pkg::addr_t'(pair_upper ? addr_hi : addr_lo);
    end

    assign rd_valid        = state[i_rd0] | state[i_rd1];
    assign pair_upper      = state[i_rd1];
    assign tw_en           = state[i_rd1];  // rom output lines up with sample b
    assign tw_idx          = k << stage;
    assign stage_last_pair = state[i_rd1] & last_k & last_group;
    assign done            = state[i_done];
    assign busy            = ~state[i_idle];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (state)
            st_idle:  state_nxt = start ? st_rd0 : st_idle;
            st_rd0:   state_nxt = st_rd1;
            st_rd1:   state_nxt = stage_last_pair ? st_drain : st_rd0;
            st_drain: begin
                if (drain_end) begin
                    state_nxt = last_stage ? st_done : st_rd0;
                end else begin
                    state_nxt = st_drain;
                end
            end
            st_done:  state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            stage     <= '0;
            group     <= '0;
            k         <= '0;
            drain_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state[i_idle]) begin
                stage     <= '0;
                group     <= '0;
                k         <= '0;
                drain_cnt <= '0;
            end
            if (state[i_rd1]) begin
                if (last_k) begin
                    k     <= '0;
                    group <= last_group ? '0 : group + 1'b1;
                end else begin
                    k <= k + 1'b1;
                end
            end
            if (state[i_drain]) begin
                drain_cnt <= drain_end ? 2'd0 : drain_cnt + 2'd1;
                if (drain_end) begin
                    stage <= last_stage ? '0 : stage + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fft_butterfly.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly (
    input  logic                clk,
    input  logic                rst_n,
    input  fft_pkg::cplx_t      rd_data,
    input  logic                sample_valid,
    input  logic                pair_upper,
    input  fft_pkg::twiddle_t   tw,
    input  fft_pkg::addr_t      wr_addr_in,
    output fft_pkg::wr_req_t    wr_req,
    output logic                wr_valid
);

    localparam int dw = fft_pkg::data_w;
    localparam int fb = fft_pkg::coef_frac;
    localparam int pw = fft_pkg::data_w + fft_pkg::coef_w + 2;

    localparam logic signed [pw-1:0] rnd_half = 1 <<< fb;  // half lsb after the final shift

    logic                   s1_valid;   // read strobe, delayed to meet ram data
    logic                   s1_upper;
    fft_pkg::addr_t         s1_addr;

    fft_pkg::cplx_t         a_q;
    fft_pkg::cplx_t         b_q;
    fft_pkg::twiddle_t      w_q;
    fft_pkg::addr_t         addr_a;
    fft_pkg::addr_t         addr_b;
    logic                   pair_rdy;

    logic signed [dw:0]     sum_re;
    logic signed [dw:0]     sum_im;
    logic signed [dw:0]     dif_re;
    logic signed [dw:0]     dif_im;
    logic signed [pw-1:0]   prod_re;
    logic signed [pw-1:0]   prod_im;

    fft_pkg::cplx_t         sum_q;
    fft_pkg::cplx_t         dif_q;
    fft_pkg::addr_t         wb_addr_a;
    fft_pkg::addr_t         wb_addr_b;
    logic                   wb_sum;
    logic                   wb_dif;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_upper <= 1'b0;
            pair_rdy <= 1'b0;
            wb_sum   <= 1'b0;
            wb_dif   <= 1'b0;
        end else begin
            s1_valid <= sample_valid;
            s1_upper <= pair_upper;
            pair_rdy <= s1_valid & s1_upper;  // b is in, compute next cycle
            wb_sum   <= pair_rdy;
            wb_dif   <= wb_sum;
        end
    end

    // capture a, then b with its twiddle
    always_ff @(posedge clk) begin
        s1_addr <= wr_addr_in;
        if (s1_valid && !s1_upper) begin
            a_q    <= rd_data;
            addr_a <= s1_addr;
        end
        if (s1_valid && s1_upper) begin
            b_q    <= rd_data;
            w_q    <= tw;
            addr_b <= s1_addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dif butterfly, both outputs scaled by one half
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sum_re  = $signed(a_q.re) + $signed(b_q.re);
        sum_im  = $signed(a_q.im) + $signed(b_q.im);
        dif_re  = $signed(a_q.re) - $signed(b_q.re);
        dif_im  = $signed(a_q.im) - $signed(b_q.im);
        prod_re = dif_re * $signed(w_q.cos) - dif_im * $signed(w_q.sin) + rnd_half;
        prod_im = dif_re * $signed(w_q.sin) + dif_im * $signed(w_q.cos) + rnd_half;
    end

    always_ff @(posedge clk) begin
        if (pair_rdy) begin
            sum_q.re  <= sum_re[dw:1];
            sum_q.im  <= sum_im[dw:1];
            dif_q.re  <= prod_re[fb+dw:fb+1];   // drop q1.14 fraction plus one more bit
            dif_q.im  <= prod_im[fb+dw:fb+1];
            wb_addr_a <= addr_a;
            wb_addr_b <= addr_b;
        end
    end

    // sum result first, twiddled difference the cycle after
    always_comb begin
        wr_req.addr = wb_sum ? wb_addr_a : wb_addr_b;
        wr_req.data = wb_sum ? sum_q : dif_q;
    end

    assign wr_valid = wb_sum | wb_dif;

endmodule

`default_nettype wire

// ==== logic/fft_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft_core #(
    parameter int n_points = 16,
    parameter int log2_n   = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                load_en,
    input  fft_pkg::addr_t      load_addr,
    input  fft_pkg::cplx_t      load_data,
    input  logic                rd_en,
    input  fft_pkg::addr_t      rd_addr,
    output fft_pkg::cplx_t      rd_data,
    output logic                done,
    output logic                host_wait
);

    fft_pkg::rd_req_t   ag_rd_req;
    logic               ag_rd_valid;
    logic               ag_pair_upper;
    logic               ag_busy;
    logic [log2_n-2:0]  tw_idx;
    logic               tw_en;
    fft_pkg::twiddle_t  tw;

    fft_pkg::wr_req_t   bf_wr_req;
    logic               bf_wr_valid;

    fft_pkg::wr_req_t   host_wr_req;
    fft_pkg::rd_req_t   host_rd_req;
    fft_pkg::wr_req_t   ram_wr_req;
    logic               wr_grant_valid;
    logic               ram_wr_valid;
    fft_pkg::rd_req_t   ram_rd_req;
    logic               ram_rd_valid;
    logic               wr_lost;
    logic               rd_lost;

    assign host_wr_req = '{addr: load_addr, data: load_data};
    assign host_rd_req = '{addr: rd_addr};

    // engine owns both ports while busy; only real butterfly writes land
    assign ram_wr_valid = wr_grant_valid & (bf_wr_valid | ~ag_busy);
    assign host_wait    = wr_lost | rd_lost;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fft_addr_gen #(
        .n_points (n_points),
        .log2_n   (log2_n)
    ) u_addr_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .rd_req          (ag_rd_req),
        .rd_valid        (ag_rd_valid),
        .tw_idx          (tw_idx),
        .tw_en           (tw_en),
        .pair_upper      (ag_pair_upper),
        .stage_last_pair (),
        .done            (done),
        .busy            (ag_busy)
    );

    twiddle_rom #(
        .n_points (n_points)
    ) u_twiddle_rom (
        .clk    (clk),
        .tw_en  (tw_en),
        .tw_idx (tw_idx),
        .tw     (tw)
    );

    fft_butterfly u_butterfly (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_data      (rd_data),
        .sample_valid (ag_rd_valid),
        .pair_upper   (ag_pair_upper),
        .tw           (tw),
        .wr_addr_in   (ag_rd_req.addr),
        .wr_req       (bf_wr_req),
        .wr_valid     (bf_wr_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mem_port_arbiter #(
        .req_t (fft_pkg::wr_req_t)
    ) wr_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .pri_req     (bf_wr_req),
        .pri_valid   (ag_busy),
        .sec_req     (host_wr_req),
        .sec_valid   (load_en),
        .grant_req   (ram_wr_req),
        .grant_valid (wr_grant_valid),
        .sec_lost    (wr_lost)
    );

    mem_port_arbiter #(
        .req_t (fft_pkg::rd_req_t)
    ) rd_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .pri_req     (ag_rd_req),
        .pri_valid   (ag_busy),
        .sec_req     (host_rd_req),
        .sec_valid   (rd_en),
        .grant_req   (ram_rd_req),
        .grant_valid (ram_rd_valid),
        .sec_lost    (rd_lost)
    );

    sample_ram #(
        .n_points (n_points)
    ) u_sample_ram (
        .clk      (clk),
        .wr       (ram_wr_req),
        .wr_valid (ram_wr_valid),
        .rd       (ram_rd_req),
        .rd_valid (ram_rd_valid),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int data_w    = 16;  // one real or imaginary part
    localparam int coef_w    = 16;  // twiddle part, Q1.14
    localparam int coef_frac = 14;  // fraction bits of a twiddle part
    localparam int addr_w    = 8;   // enough for 256 points

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [addr_w-1:0] addr_t;

    typedef struct packed {
        logic signed [data_w-1:0] re;
        logic signed [data_w-1:0] im;
    } cplx_t;

    // sin holds -sin(2*pi*j/N), so the twiddle is cos + j*sin
    typedef struct packed {
        logic signed [coef_w-1:0] cos;
        logic signed [coef_w-1:0] sin;
    } twiddle_t;

    typedef struct packed {
        addr_t addr;
        cplx_t data;
    } wr_req_t;

    typedef struct packed {
        addr_t addr;
    } rd_req_t;

endpackage

`default_nettype wire

// ==== logic/mem_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter #(
    parameter type req_t = logic
) (
    input  logic    clk,
    input  logic    rst_n,
    input  req_t    pri_req,
    input  logic    pri_valid,
    input  req_t    sec_req,
    input  logic    sec_valid,
    output req_t    grant_req,
    output logic    grant_valid,
    output logic    sec_lost
);

    logic collide;

    // primary side always wins the port
    assign collide     = pri_valid & sec_valid;
    assign grant_req   = pri_valid ? pri_req : sec_req;
    assign grant_valid = pri_valid | sec_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // loss flag, seen by the host one cycle on
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sec_lost <= 1'b0;
        end else begin
            sec_lost <= collide;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sample_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
    parameter int n_points = 16
) (
    input  logic                clk,
    input  fft_pkg::wr_req_t    wr,
    input  logic                wr_valid,
    input  fft_pkg::rd_req_t    rd,
    input  logic                rd_valid,
    output fft_pkg::cplx_t      rd_data
);

    localparam int aw = $clog2(n_points);

    fft_pkg::cplx_t mem [n_points];

    // write and read in one block, so a same-address read sees old data
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr.addr[aw-1:0]] <= wr.data;
        end
        if (rd_valid) begin
            rd_data <= mem[rd.addr[aw-1:0]];  // registered read port
        end
    end

endmodule

`default_nettype wire

// ==== logic/twiddle_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module twiddle_rom #(
    parameter int  n_points = 16,
    localparam int idx_w    = $clog2(n_points) - 1
) (
    input  logic                clk,
    input  logic                tw_en,
    input  logic [idx_w-1:0]    tw_idx,
    output fft_pkg::twiddle_t   tw
);

    localparam real pi    = 3.141592653589793;
    localparam real scale = real'(1 << fft_pkg::coef_frac);

    fft_pkg::twiddle_t table_q [n_points/2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table, one entry per twiddle index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar j = 0; j < n_points/2; j++) begin : g_tab
        localparam real ang   = 2.0 * pi * j / n_points;
        localparam int  c_val = int'(scale * $cos(ang));   // int' rounds to nearest
        localparam int  s_val = int'(-scale * $sin(ang));

        assign table_q[j].cos = fft_pkg::coef_w'(c_val);
        assign table_q[j].sin = fft_pkg::coef_w'(s_val);
    end

    // one cycle of latency
    always_ff @(posedge clk) begin
        if (tw_en) begin
            tw <= table_q[tw_idx];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the fft_core testbench with verilator, run it, judge the log
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module fft_core_tb -f verilog.f \
    && ./obj_dir/Vfft_core_tb > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/fft_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft_checker #(
    parameter int n_points  = 16,
    parameter int log2_n    = 4,
    parameter int tolerance = 2     // lsb, for twiddle rounding
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            done,
    input  logic                            rd_en,
    input  fft_pkg::addr_t                  rd_addr,
    input  fft_pkg::cplx_t                  rd_data,
    input  logic                            host_wait,
    input  logic [8*12-1:0]                 test_name,
    input  fft_pkg::cplx_t [n_points-1:0]   expected,  // indexed by bin
    output int                              value_errors,
    output int                              other_errors
);

    logic           engine_busy;    // mirrors the core's busy from start to done
    logic           done_prev;
    logic           rd_pending;     // accepted read, data due now
    logic           drop_pending;   // read made while busy, host_wait due now
    fft_pkg::addr_t pend_addr;

    int v_err       = 0;
    int o_err       = 0;
    int done_count  = 0;
    int stall_count = 0;

    assign value_errors = v_err;
    assign other_errors = o_err;

    function automatic int bit_reverse(input int a);
        int r;
        r = 0;
        for (int i = 0; i < log2_n; i++) begin
            r = (r << 1) | ((a >> i) & 1);
        end
        return r;
    endfunction

    function automatic bit within_tol(input int actual, input int want);
        return (actual - want <= tolerance) && (want - actual <= tolerance);
    endfunction

    task automatic compare_bin(input fft_pkg::addr_t addr, input fft_pkg::cplx_t actual);
        int             bin;
        fft_pkg::cplx_t want;
        bin  = bit_reverse(int'(addr));  // results sit in bit-reversed order
        want = expected[bin[log2_n-1:0]];
        if (!within_tol(actual.re, want.re) || !within_tol(actual.im, want.im)) begin
            v_err++;
            $display("Error %0s addr %0d bin %0d expected (%0d,%0d) actual (%0d,%0d)",
                     test_name, addr, bin, want.re, want.im, actual.re, actual.im);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            engine_busy  <= 1'b0;
            done_prev    <= 1'b0;
            rd_pending   <= 1'b0;
            drop_pending <= 1'b0;
            pend_addr    <= '0;
        end else begin
            if (rd_pending) begin
                if (host_wait) begin
                    o_err++;
                    $display("%0s: host read of addr %0d was refused with the engine idle",
                             test_name, pend_addr);
                end else begin
                    compare_bin(pend_addr, rd_data);
                end
            end
            if (drop_pending) begin
                if (host_wait) begin
                    stall_count++;
                end else begin
                    v_err++;
                    $display("Error %0s host_wait expected 1 actual 0", test_name);
                end
            end
            if (done) begin
                done_count++;
                if (done_prev) begin
                    o_err++;
                    $display("%0s: done stayed high for more than one cycle", test_name);
                end
                if (!engine_busy) begin
                    o_err++;
                    $display("%0s: done pulsed without a start", test_name);
                end
            end
            rd_pending   <= rd_en & ~engine_busy;
            drop_pending <= rd_en & engine_busy;
            pend_addr    <= rd_addr;
            done_prev    <= done;
            if (start) begin
                engine_busy <= 1'b1;
            end else if (done) begin
                engine_busy <= 1'b0;
            end
        end
    end

    // totals over the whole run, called once at the end
    task automatic check_totals(input int starts);
        if (done_count != starts) begin
            o_err++;
            $display("done pulsed %0d times for %0d starts", done_count, starts);
        end
        if (stall_count != starts) begin
            o_err++;
            $display("only %0d of %0d reads during a run got host_wait", stall_count, starts);
        end
    endtask

endmodule

`default_nettype wire

// ==== test/fft_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft_core_tb;

    localparam int  n_points       = 16;
    localparam int  log2_n         = 4;
    localparam int  num_cases      = 4;
    localparam int  run_cycles     = 78;
    localparam int  reset_cycles   = 10;
    localparam int  timeout_cycles = num_cases * (run_cycles + 40) + 100;
    localparam real pi             = 3.141592653589793;

    // 3200 * cos(2*pi*3*n/16), rounded
    localparam int tone_samples [n_points] = '{
        3200, 1225, -2263, -2956, 0, 2956, 2263, -1225,
        -3200, -1225, 2263, 2956, 0, -2956, -2263, 1225
    };

    logic           clk;
    logic           rst_n;
    logic           start;
    logic           load_en;
    fft_pkg::addr_t load_addr;
    fft_pkg::cplx_t load_data;
    logic           rd_en;
    fft_pkg::addr_t rd_addr;
    fft_pkg::cplx_t rd_data;
    logic           done;
    logic           host_wait;

    // case table
    logic [8*12-1:0]                case_name [num_cases];
    fft_pkg::cplx_t                 case_in   [num_cases][n_points];
    fft_pkg::cplx_t                 case_exp  [num_cases][n_points];
    logic [8*12-1:0]                cur_name;
    fft_pkg::cplx_t [n_points-1:0]  cur_exp;

    int cycle_count = 0;
    int value_errors;
    int other_errors;

    fft_core #(
        .n_points (n_points),
        .log2_n   (log2_n)
    ) fft_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .done      (done),
        .host_wait (host_wait)
    );

    fft_checker #(
        .n_points (n_points),
        .log2_n   (log2_n)
    ) result_check (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .done         (done),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .host_wait    (host_wait),
        .test_name    (cur_name),
        .expected     (cur_exp),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic fft_pkg::cplx_t make_cplx(input int re_v, input int im_v);
        fft_pkg::cplx_t c;
        c.re = re_v[15:0];
        c.im = im_v[15:0];
        return c;
    endfunction

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // random samples, expected bins from a direct dft scaled by 1/N
    task automatic fill_random(input int c);
        int  xr [n_points];
        int  xi [n_points];
        real acc_re;
        real acc_im;
        real ang;
        for (int i = 0; i < n_points; i++) begin
            xr[i] = int'($urandom_range(4000)) - 2000;
            xi[i] = int'($urandom_range(4000)) - 2000;
            case_in[c][i] = make_cplx(xr[i], xi[i]);
        end
        for (int k = 0; k < n_points; k++) begin
            acc_re = 0.0;
            acc_im = 0.0;
            for (int i = 0; i < n_points; i++) begin
                ang    = 2.0 * pi * real'(k * i) / real'(n_points);
                acc_re = acc_re + real'(xr[i]) * $cos(ang) + real'(xi[i]) * $sin(ang);
                acc_im = acc_im + real'(xi[i]) * $cos(ang) - real'(xr[i]) * $sin(ang);
            end
            case_exp[c][k] = make_cplx(int'(acc_re / real'(n_points)),
                                       int'(acc_im / real'(n_points)));
        end
    endtask

    task automatic build_cases();
        case_name[0] = "impulse";
        case_name[1] = "dc";
        case_name[2] = "tone_bin3";
        case_name[3] = "random";
        for (int i = 0; i < n_points; i++) begin
            case_in[0][i]  = make_cplx((i == 0) ? 1600 : 0, 0);
            case_exp[0][i] = make_cplx(100, 0);                        // 1600 / 16
            case_in[1][i]  = make_cplx(800, 0);
            case_exp[1][i] = make_cplx((i == 0) ? 800 : 0, 0);
            case_in[2][i]  = make_cplx(tone_samples[i], 0);
            case_exp[2][i] = make_cplx((i == 3 || i == 13) ? 1600 : 0, 0);
        end
        fill_random(3);
    endtask

    task automatic wait_done();
        do begin
            next_cycle();
        end while (!done);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one case: load, start, stalled read, unload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_case(input int c);
        cur_name = case_name[c];
        for (int i = 0; i < n_points; i++) begin
            cur_exp[i] = case_exp[c][i];
        end
        for (int i = 0; i < n_points; i++) begin
            load_en   = 1'b1;
            load_addr = fft_pkg::addr_t'(i);
            load_data = case_in[c][i];
            next_cycle();
        end
        load_en = 1'b0;
        start   = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (6) next_cycle();
        rd_en   = 1'b1;                         // engine busy, must be dropped
        rd_addr = fft_pkg::addr_t'(c + 1);
        next_cycle();
        rd_en = 1'b0;
        wait_done();
        next_cycle();                           // core back in idle
        for (int a = 0; a < n_points; a++) begin
            rd_en   = 1'b1;
            rd_addr = fft_pkg::addr_t'(a);
            next_cycle();
        end
        rd_en = 1'b0;
        next_cycle();                           // last read data compared here
    endtask

    initial begin
        void'($urandom(82948));
        rst_n     = 1'b0;
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        cur_name  = "reset";
        cur_exp   = '0;
        build_cases();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        result_check.check_totals(num_cases);
        next_cycle();
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("timeout after %0d cycles in %0s, done never arrived", cycle_count, cur_name);
        $display("value errors %0d, other errors %0d", value_errors, other_errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/fft_pkg.sv
logic/fft_addr_gen.sv
logic/twiddle_rom.sv
logic/fft_butterfly.sv
logic/mem_port_arbiter.sv
logic/sample_ram.sv
logic/fft_core.sv
test/fft_checker.sv
test/fft_core_tb.sv
